//--- verilog/exec_config.svh
// Execute cluster build options
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// ==========================================================================
// Stream credits and queue depths
// ==========================================================================

// Instruction queue depth, which is also the sender's starting credit
`define INSTR_CREDITS 4

// Entries in the load-return buffer
`define LOAD_CREDITS 2

// Results the consumer can take before it must hand credits back
`define RESULT_CREDITS 4

// Architectural register count
`define REG_COUNT 16

// Non-zero builds the register-amount shifts (ASL_RRR, LSR_RRR)
`define SUPPORT_SHIFT 1

`endif

//--- verilog/execPkg.sv
// Execute cluster shared types
package execPkg;

	// ======================================================================
	// Register numbers and opcodes
	// ======================================================================

	typedef logic [3:0] regAddr;

	typedef enum logic [7:0] {
		// Register/register group
		ADD_RR  = 8'h10,
		SUB_RR  = 8'h11,
		AND_RR  = 8'h12,
		OR_RR   = 8'h13,
		EOR_RR  = 8'h14,
		ASL_RRR = 8'h15,
		LSR_RRR = 8'h16,
		// Immediate group
		ADD_IMM = 8'h20,
		SUB_IMM = 8'h21,
		AND_IMM = 8'h22,
		OR_IMM  = 8'h23,
		EOR_IMM = 8'h24,
		LD_IMM  = 8'h25,
		// Single operand group, source is ra
		SXB     = 8'h30,
		ZXB     = 8'h31,
		RBO     = 8'h32,
		NOT     = 8'h33,
		COM     = 8'h34,
		INC     = 8'h35,
		DEC     = 8'h36,
		ASL     = 8'h37,
		LSR     = 8'h38,
		ROL     = 8'h39,
		ROR     = 8'h3A
	} aluOp;

	// ======================================================================
	// Instruction word
	// ======================================================================

	// Opcode sits in bits 7..0, rt in 11..8 and ra in 15..12 in both forms
	// The upper half is either rb plus the carry select, or an immediate
	typedef struct packed {
		logic [10:0] spare;
		logic        withCarry;
		regAddr      rb;
		regAddr      ra;
		regAddr      rt;
		aluOp        opcode;
	} rrInstr;

	typedef struct packed {
		logic [15:0] imm;
		regAddr      ra;
		regAddr      rt;
		aluOp        opcode;
	} immInstr;

	typedef union packed {
		rrInstr  regForm;
		immInstr immForm;
	} instrWord;

endpackage

//--- verilog/regWriteIf.sv
// Register file write request channel
`timescale 1ns/1ps

interface regWriteIf;
	import execPkg::*;

	// Requester holds req, addr and data steady until it sees gnt
	logic        req;
	regAddr      addr;
	logic [31:0] data;
	// One-cycle grant, the write lands on the clock edge closing it
	logic        gnt;

	modport requester (
		output req,
		output addr,
		output data,
		input  gnt
	);

	modport arbiter (
		input  req,
		input  addr,
		input  data,
		output gnt
	);

endinterface

//--- verilog/creditFifo.sv
// Credit returning FIFO
`timescale 1ns/1ps

module creditFifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 4
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             push,
	input  logic [WIDTH-1:0] pushData,
	input  logic             pop,
	output logic             headValid,
	output logic [WIDTH-1:0] headData,
	output logic             credit
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W-1:0] wrPtr;
	logic [CNT_W-1:0] count;
	logic             doPush;
	logic             doPop;

	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign headValid = (count != '0);
	assign headData = mem[rdPtr];
	assign doPop = pop & headValid;
	assign doPush = push & (count != CNT_W'(DEPTH));

	// Every pop hands one credit back to the sender in the same cycle
	assign credit = doPop;

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

endmodule

//--- verilog/intAlu.sv
// Integer result unit
`timescale 1ns/1ps
`include "exec_config.svh"

module intAlu (
	input  execPkg::instrWord instr,
	input  logic [31:0]       ra,
	input  logic [31:0]       rb,
	input  logic              carry,
	output logic [32:0]       res
);
	import execPkg::*;

	logic [31:0] immExt;
	logic [32:0] carryIn;
	logic [32:0] borrowIn;
	logic [31:0] shlo;
	logic [31:0] shro;

	// Immediates are always sign extended from 16 bits
	assign immExt = {{16{instr.immForm.imm[15]}}, instr.immForm.imm};

	// Carry chains only apply when the instruction asks for them
	assign carryIn = {32'd0, instr.regForm.withCarry & carry};
	assign borrowIn = {32'd0, instr.regForm.withCarry & ~carry};

	assign shlo = (`SUPPORT_SHIFT != 0) ? (ra << rb[4:0]) : 32'd0;
	assign shro = (`SUPPORT_SHIFT != 0) ? (ra >> rb[4:0]) : 32'd0;

	// ======================================================================
	// Result select
	// ======================================================================
	always_comb
	begin
		case (instr.regForm.opcode)
			// Bit 32 of a subtract ends up as the borrow
			ADD_RR:  res = {1'b0, ra} + {1'b0, rb} + carryIn;
			SUB_RR:  res = {1'b0, ra} - {1'b0, rb} - borrowIn;
			AND_RR:  res = {1'b0, ra & rb};
			OR_RR:   res = {1'b0, ra | rb};
			EOR_RR:  res = {1'b0, ra ^ rb};
			ASL_RRR: res = {1'b0, shlo};
			LSR_RRR: res = {1'b0, shro};

			ADD_IMM: res = {1'b0, ra} + {1'b0, immExt};
			SUB_IMM: res = {1'b0, ra} - {1'b0, immExt};
			AND_IMM: res = {1'b0, ra & immExt};
			OR_IMM:  res = {1'b0, ra | immExt};
			EOR_IMM: res = {1'b0, ra ^ immExt};
			LD_IMM:  res = {1'b0, immExt};

			SXB:     res = {1'b0, {24{ra[7]}}, ra[7:0]};
			ZXB:     res = {25'd0, ra[7:0]};
			RBO:     res = {1'b0, ra[7:0], ra[15:8], ra[23:16], ra[31:24]};
			NOT:     res = {32'd0, ra == 32'd0};
			COM:     res = {1'b0, ~ra};
			INC:     res = {1'b0, ra} + 33'd1;
			DEC:     res = {1'b0, ra} - 33'd1;

			// One-bit shifts move the outgoing bit into bit 32
			ASL:     res = {ra, 1'b0};
			ROL:     res = {ra, carry};
			LSR:     res = {ra[0], 1'b0, ra[31:1]};
			ROR:     res = {ra[0], carry, ra[31:1]};
			default: res = 33'd0;
		endcase
	end

endmodule

//--- verilog/executeStage.sv
// Single-entry execute stage
`timescale 1ns/1ps
`include "exec_config.svh"

module executeStage (
	input  logic              clk,
	input  logic              reset,
	input  logic              headValid,
	input  execPkg::instrWord instr,
	output logic              pop,
	output execPkg::regAddr   raAddr,
	output execPkg::regAddr   rbAddr,
	input  logic [31:0]       raData,
	input  logic [31:0]       rbData,
	input  logic              resCredit,
	regWriteIf.requester      wr,
	output logic              resValid,
	output execPkg::regAddr   resReg,
	output logic [32:0]       resData
);
	import execPkg::*;

	localparam int CRED_W = $clog2(`RESULT_CREDITS + 1);

	logic [32:0]       aluRes;
	logic              setsCarry;
	logic              holdValid;
	logic [32:0]       heldRes;
	regAddr            heldRt;
	logic              heldSetsCarry;
	logic              carryFlag;
	logic [CRED_W-1:0] creditCount;

	intAlu alu (
		.instr (instr),
		.ra    (raData),
		.rb    (rbData),
		.carry (carryFlag),
		.res   (aluRes)
	);

	// Operand reads come straight from the queue head
	assign raAddr = instr.regForm.ra;
	assign rbAddr = instr.regForm.rb;

	// Ops whose bit 32 becomes the new carry flag
	always_comb
	begin
		case (instr.regForm.opcode)
			ADD_RR, SUB_RR, ADD_IMM, SUB_IMM, ASL, LSR, ROL, ROR:
				setsCarry = 1'b1;
			default:
				setsCarry = 1'b0;
		endcase
	end

	// Take a new instruction only when the holding slot is free and the
	// consumer still has room for its result
	assign pop = headValid & ~holdValid & (creditCount != '0);

	assign wr.req = holdValid;
	assign wr.addr = heldRt;
	assign wr.data = heldRes[31:0];

	// The result is reported in the cycle its register write is granted
	assign resValid = holdValid & wr.gnt;
	assign resReg = heldRt;
	assign resData = heldRes;

	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			heldRes <= aluRes;
			heldRt <= instr.regForm.rt;
			heldSetsCarry <= setsCarry;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			holdValid <= 1'b0;
			carryFlag <= 1'b0;
			creditCount <= CRED_W'(`RESULT_CREDITS);
		end
		else
		begin
			if (pop)
				holdValid <= 1'b1;
			else if (resValid)
				holdValid <= 1'b0;
			if (resValid && heldSetsCarry)
				carryFlag <= heldRes[32];
			// A credit is spent as the result leaves
			if (resValid && !resCredit)
				creditCount <= creditCount - 1'b1;
			else if (resCredit && !resValid)
				creditCount <= creditCount + 1'b1;
		end
	end

endmodule

//--- verilog/writeArbiter.sv
// Register file write port arbiter
`timescale 1ns/1ps

module writeArbiter (
	input  logic            clk,
	input  logic            reset,
	regWriteIf.arbiter      execPort,
	regWriteIf.arbiter      loadPort,
	output logic            we,
	output execPkg::regAddr waddr,
	output logic [31:0]     wdata
);

	logic grantExec;
	logic grantLoad;
	logic lastWasLoad;

	// Round robin between the two peers; a lone requester always wins
	assign grantExec = execPort.req & (~loadPort.req | lastWasLoad);
	assign grantLoad = loadPort.req & ~grantExec;

	assign execPort.gnt = grantExec;
	assign loadPort.gnt = grantLoad;

	assign we = grantExec | grantLoad;
	assign waddr = grantLoad ? loadPort.addr : execPort.addr;
	assign wdata = grantLoad ? loadPort.data : execPort.data;

	// Starting as if the load side went last gives the execute stage
	// the first contested grant
	always_ff @(posedge clk)
	begin
		if (reset)
			lastWasLoad <= 1'b1;
		else if (grantExec)
			lastWasLoad <= 1'b0;
		else if (grantLoad)
			lastWasLoad <= 1'b1;
	end

endmodule

//--- verilog/regFile.sv
// Two-read one-write register file
`timescale 1ns/1ps
`include "exec_config.svh"

module regFile (
	input  logic            clk,
	input  logic            reset,
	input  execPkg::regAddr raAddr,
	input  execPkg::regAddr rbAddr,
	output logic [31:0]     raData,
	output logic [31:0]     rbData,
	input  logic            we,
	input  execPkg::regAddr waddr,
	input  logic [31:0]     wdata
);

	logic [31:0] regs [`REG_COUNT];

	// Reads are combinational and see a write only after its edge
	assign raData = regs[raAddr];
	assign rbData = regs[rbAddr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= 32'd0;
		end
		else if (we)
		begin
			regs[waddr] <= wdata;
		end
	end

endmodule

//--- verilog/execCluster.sv
// Integer execute cluster top
`timescale 1ns/1ps
`include "exec_config.svh"

module execCluster (
	input  logic              clk,
	input  logic              reset,
	input  logic              instrValid,
	input  execPkg::instrWord instr,
	output logic              instrCredit,
	input  logic              loadValid,
	input  execPkg::regAddr   loadReg,
	input  logic [31:0]       loadData,
	output logic              loadCredit,
	input  logic              resCredit,
	output logic              resValid,
	output execPkg::regAddr   resReg,
	output logic [32:0]       resData
);
	import execPkg::*;

	localparam int LOAD_W = $bits(regAddr) + 32;

	instrWord          instrHead;
	logic              instrHeadValid;
	logic              instrPop;
	logic [LOAD_W-1:0] loadHead;
	logic              loadHeadValid;
	regAddr            raAddr;
	regAddr            rbAddr;
	logic [31:0]       raData;
	logic [31:0]       rbData;
	logic              we;
	regAddr            waddr;
	logic [31:0]       wdata;

	regWriteIf execWr ();
	regWriteIf loadWr ();

	// ======================================================================
	// Input queues
	// ======================================================================
	creditFifo #(.WIDTH(32), .DEPTH(`INSTR_CREDITS)) instrQueue (
		.clk       (clk),
		.reset     (reset),
		.push      (instrValid),
		.pushData  (instr),
		.pop       (instrPop),
		.headValid (instrHeadValid),
		.headData  (instrHead),
		.credit    (instrCredit)
	);

	// The load buffer drains as soon as its write is granted
	creditFifo #(.WIDTH(LOAD_W), .DEPTH(`LOAD_CREDITS)) loadQueue (
		.clk       (clk),
		.reset     (reset),
		.push      (loadValid),
		.pushData  ({loadReg, loadData}),
		.pop       (loadWr.gnt),
		.headValid (loadHeadValid),
		.headData  (loadHead),
		.credit    (loadCredit)
	);

	assign loadWr.req = loadHeadValid;
	assign loadWr.addr = loadHead[LOAD_W-1:32];
	assign loadWr.data = loadHead[31:0];

	// ======================================================================
	// Execute, arbitration and registers
	// ======================================================================
	executeStage exec (
		.clk       (clk),
		.reset     (reset),
		.headValid (instrHeadValid),
		.instr     (instrHead),
		.pop       (instrPop),
		.raAddr    (raAddr),
		.rbAddr    (rbAddr),
		.raData    (raData),
		.rbData    (rbData),
		.resCredit (resCredit),
		.wr        (execWr.requester),
		.resValid  (resValid),
		.resReg    (resReg),
		.resData   (resData)
	);

	writeArbiter arbiter (
		.clk      (clk),
		.reset    (reset),
		.execPort (execWr.arbiter),
		.loadPort (loadWr.arbiter),
		.we       (we),
		.waddr    (waddr),
		.wdata    (wdata)
	);

	regFile regs (
		.clk    (clk),
		.reset  (reset),
		.raAddr (raAddr),
		.rbAddr (rbAddr),
		.raData (raData),
		.rbData (rbData),
		.we     (we),
		.waddr  (waddr),
		.wdata  (wdata)
	);

endmodule

//--- bench/clockGen.sv
// Bench clock and reset
`timescale 1ns/1ps

module clockGen (
	output logic clk,
	output logic reset
);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Reset held high across the first four rising edges
	initial
	begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

//--- bench/execCluster_properties.sv
// Execute cluster assertions
`timescale 1ns/1ps
`include "exec_config.svh"

module execCluster_properties #(
	parameter int CRED_W = $clog2(`RESULT_CREDITS + 1),
	parameter int CNT_W = $clog2(`INSTR_CREDITS + 1)
) (
	input logic              clk,
	input logic              reset,
	input logic              execGnt,
	input logic              loadGnt,
	input logic              resValid,
	input logic [CRED_W-1:0] creditCount,
	input logic              push,
	input logic [CNT_W-1:0]  queueCount
);

	grantsExclusive: assert property (@(posedge clk) disable iff (reset)
		!(execGnt && loadGnt))
		else $error("Both register write grants are high");

	resultNeedsCredit: assert property (@(posedge clk) disable iff (reset)
		resValid |-> (creditCount != '0))
		else $error("Result reported with no result credit left");

	noPushWhenFull: assert property (@(posedge clk) disable iff (reset)
		push |-> (queueCount != CNT_W'(`INSTR_CREDITS)))
		else $error("Instruction queue pushed while full");

endmodule

bind execCluster execCluster_properties props (
	.clk         (clk),
	.reset       (reset),
	.execGnt     (execWr.gnt),
	.loadGnt     (loadWr.gnt),
	.resValid    (resValid),
	.creditCount (exec.creditCount),
	.push        (instrValid),
	.queueCount  (instrQueue.count)
);

//--- bench/execCluster_tb.sv
// Execute cluster testbench
`timescale 1ns/1ps
`include "exec_config.svh"

module execCluster_tb;
	import execPkg::*;

	logic        clk;
	logic        reset;
	logic        instrValid;
	instrWord    instr;
	logic        instrCredit;
	logic        loadValid;
	regAddr      loadReg;
	logic [31:0] loadData;
	logic        loadCredit;
	logic        resCredit;
	logic        resValid;
	regAddr      resReg;
	logic [32:0] resData;

	// Stimulus table with one entry per instruction
	string       rowName[$];
	instrWord    rowInstr[$];
	logic [32:0] rowExp[$];
	logic        rowLoad[$];
	regAddr      rowLoadReg[$];
	logic [31:0] rowLoadData[$];
	logic        rowSync[$];

	logic [31:0] mRegs [16];
	logic        mCarry;
	aluOp        opList [24];

	int   errors;
	int   cycles;
	int   cycleLimit;
	int   sent;
	int   instrReturned;
	int   loadsSent;
	int   loadReturned;
	int   gotCount;
	int   owed;
	int   heldResults;
	int   holdStart;
	logic holdCredits;
	logic doCredit;

	clockGen clkGen (.clk(clk), .reset(reset));

	execCluster execCluster_i (
		.clk         (clk),
		.reset       (reset),
		.instrValid  (instrValid),
		.instr       (instr),
		.instrCredit (instrCredit),
		.loadValid   (loadValid),
		.loadReg     (loadReg),
		.loadData    (loadData),
		.loadCredit  (loadCredit),
		.resCredit   (resCredit),
		.resValid    (resValid),
		.resReg      (resReg),
		.resData     (resData)
	);

	// ======================================================================
	// Reference model
	// ======================================================================
	function automatic logic [32:0] modelResult(instrWord w, logic [31:0] a, logic [31:0] b,
			logic c);
		logic [31:0] imm;
		logic [32:0] r;
		logic        cin;
		logic        bin;
		imm = {{16{w.immForm.imm[15]}}, w.immForm.imm};
		cin = w.regForm.withCarry & c;
		bin = w.regForm.withCarry & ~c;
		case (w.regForm.opcode)
			ADD_RR:  r = {1'b0, a} + {1'b0, b} + {32'd0, cin};
			SUB_RR:  r = {1'b0, a} - {1'b0, b} - {32'd0, bin};
			AND_RR:  r = {1'b0, a & b};
			OR_RR:   r = {1'b0, a | b};
			EOR_RR:  r = {1'b0, a ^ b};
			ASL_RRR: r = {1'b0, a << b[4:0]};
			LSR_RRR: r = {1'b0, a >> b[4:0]};
			ADD_IMM: r = {1'b0, a} + {1'b0, imm};
			SUB_IMM: r = {1'b0, a} - {1'b0, imm};
			AND_IMM: r = {1'b0, a & imm};
			OR_IMM:  r = {1'b0, a | imm};
			EOR_IMM: r = {1'b0, a ^ imm};
			LD_IMM:  r = {1'b0, imm};
			SXB:     r = {1'b0, {24{a[7]}}, a[7:0]};
			ZXB:     r = {25'd0, a[7:0]};
			RBO:     r = {1'b0, a[7:0], a[15:8], a[23:16], a[31:24]};
			NOT:     r = (a == 32'd0) ? 33'd1 : 33'd0;
			COM:     r = {1'b0, ~a};
			INC:     r = {1'b0, a} + 33'd1;
			DEC:     r = {1'b0, a} - 33'd1;
			ASL:     r = {a, 1'b0};
			ROL:     r = {a, c};
			LSR:     r = {a[0], 1'b0, a[31:1]};
			ROR:     r = {a[0], c, a[31:1]};
			default: r = 33'd0;
		endcase
		return r;
	endfunction

	function automatic logic updatesCarry(aluOp op);
		return op inside {ADD_RR, SUB_RR, ADD_IMM, SUB_IMM, ASL, LSR, ROL, ROR};
	endfunction

	function automatic instrWord rrWord(aluOp op, regAddr rt, regAddr ra, regAddr rb, logic wc);
		instrWord w;
		w = '0;
		w.regForm.opcode = op;
		w.regForm.rt = rt;
		w.regForm.ra = ra;
		w.regForm.rb = rb;
		w.regForm.withCarry = wc;
		return w;
	endfunction

	function automatic instrWord immWord(aluOp op, regAddr rt, regAddr ra, logic [15:0] imm);
		instrWord w;
		w = '0;
		w.immForm.opcode = op;
		w.immForm.rt = rt;
		w.immForm.ra = ra;
		w.immForm.imm = imm;
		return w;
	endfunction

	task automatic compareValue(string name, logic [63:0] expected, logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	// ======================================================================
	// Table construction
	// ======================================================================
	task automatic addRow(string name, instrWord w, logic [32:0] expected, logic ld,
			regAddr lr, logic [31:0] ldata, logic sync);
		rowName.push_back(name);
		rowInstr.push_back(w);
		rowExp.push_back(expected);
		rowLoad.push_back(ld);
		rowLoadReg.push_back(lr);
		rowLoadData.push_back(ldata);
		rowSync.push_back(sync);
		if (ld)
			mRegs[lr] = ldata;
		mRegs[w.regForm.rt] = expected[31:0];
		if (updatesCarry(w.regForm.opcode))
			mCarry = expected[32];
	endtask

	task automatic addModelRow(string name, instrWord w, logic ld, regAddr lr,
			logic [31:0] ldata, logic sync);
		logic [32:0] expected;
		expected = modelResult(w, mRegs[w.regForm.ra], mRegs[w.regForm.rb], mCarry);
		addRow(name, w, expected, ld, lr, ldata, sync);
	endtask

	task automatic addRandomRow(string name, aluOp op, logic ld, regAddr lr);
		instrWord w;
		w = rrWord(op, 4'($urandom_range(11, 0)), 4'($urandom_range(11, 0)),
			4'($urandom_range(11, 0)), 1'($urandom_range(1, 0)));
		if (op inside {ADD_IMM, SUB_IMM, AND_IMM, OR_IMM, EOR_IMM, LD_IMM})
			w.immForm.imm = 16'($urandom);
		addModelRow(name, w, ld, lr, $urandom, 1'b0);
	endtask

	task automatic buildTable();
		opList = '{ADD_RR, SUB_RR, AND_RR, OR_RR, EOR_RR, ASL_RRR, LSR_RRR, ADD_IMM, SUB_IMM,
			AND_IMM, OR_IMM, EOR_IMM, LD_IMM, SXB, ZXB, RBO, NOT, COM, INC, DEC, ASL, LSR,
			ROL, ROR};
		// Seeds and carry chains with hand-worked results
		addRow("ld r1", immWord(LD_IMM, 1, 0, 16'hFFFF), 33'h0FFFFFFFF, 0, 0, 0, 0);
		addRow("ld r2", immWord(LD_IMM, 2, 0, 16'h0001), 33'h000000001, 0, 0, 0, 0);
		addRow("add carry out", rrWord(ADD_RR, 3, 1, 2, 0), 33'h100000000, 0, 0, 0, 0);
		addRow("adc carry in", rrWord(ADD_RR, 4, 2, 2, 1), 33'h000000003, 0, 0, 0, 0);
		addRow("sub borrow out", rrWord(SUB_RR, 5, 2, 1, 0), 33'h100000002, 0, 0, 0, 0);
		addRow("sbc no borrow", rrWord(SUB_RR, 6, 2, 2, 1), 33'h000000000, 0, 0, 0, 0);
		addRow("sbc borrow in", rrWord(SUB_RR, 7, 2, 2, 1), 33'h1FFFFFFFF, 0, 0, 0, 0);
		addRow("adc after sbc", rrWord(ADD_RR, 8, 2, 2, 1), 33'h000000003, 0, 0, 0, 0);
		addRow("ld r9", immWord(LD_IMM, 9, 0, 16'h1234), 33'h000001234, 0, 0, 0, 0);
		addRow("rbo", rrWord(RBO, 10, 9, 0, 0), 33'h034120000, 0, 0, 0, 0);
		addRow("add imm", immWord(ADD_IMM, 11, 1, 16'hFFFF), 33'h1FFFFFFFE, 0, 0, 0, 0);
		addRow("rol", rrWord(ROL, 0, 2, 0, 0), 33'h000000003, 0, 0, 0, 0);
		// Load then read it back once its credit has returned
		addRow("ld beside load", immWord(LD_IMM, 1, 0, 16'h0007), 33'h7, 1, 12,
			32'hCAFEF00D, 0);
		addRow("load readback", immWord(OR_IMM, 9, 12, 16'h0), 33'h0CAFEF00D, 0, 0, 0, 1);
		// Every opcode runs once here on random registers
		for (int k = 0; k < 24; k++)
			addRandomRow($sformatf("random %0d", k), opList[k], k % 6 == 1,
				4'(13 + (k / 6) % 3));
		addModelRow("read r13", immWord(OR_IMM, 1, 13, 16'h0), 0, 0, 0, 1);
		addModelRow("read r14", immWord(OR_IMM, 2, 14, 16'h0), 0, 0, 0, 0);
		addModelRow("read r15", immWord(OR_IMM, 3, 15, 16'h0), 0, 0, 0, 0);
		holdStart = rowInstr.size();
		for (int k = 0; k < 6; k++)
			addRandomRow($sformatf("held %0d", k), opList[$urandom_range(23, 0)], 0, 0);
	endtask

	// ======================================================================
	// Driving and monitoring
	// ======================================================================
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic applyRows(int first, int last);
		for (int i = first; i <= last; i++)
		begin
			if (rowSync[i])
				while (loadsSent != loadReturned)
					tick();
			if (rowLoad[i])
				while (loadsSent - loadReturned >= `LOAD_CREDITS)
					tick();
			while (sent - instrReturned >= `INSTR_CREDITS)
				tick();
			instrValid = 1'b1;
			instr = rowInstr[i];
			loadValid = rowLoad[i];
			loadReg = rowLoadReg[i];
			loadData = rowLoadData[i];
			sent++;
			if (rowLoad[i])
				loadsSent++;
			tick();
			instrValid = 1'b0;
			loadValid = 1'b0;
		end
	endtask

	// Results are checked in program order and each one owes a credit
	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (instrCredit)
				instrReturned++;
			if (loadCredit)
				loadReturned++;
			if (resValid)
			begin
				if (gotCount < rowInstr.size())
				begin
					compareValue({rowName[gotCount], " reg"},
						64'(rowInstr[gotCount].regForm.rt), 64'(resReg));
					compareValue({rowName[gotCount], " data"}, 64'(rowExp[gotCount]),
						64'(resData));
				end
				else
				begin
					$display("Result appeared with no instruction left to match it");
					errors++;
				end
				gotCount++;
				owed++;
				if (holdCredits)
					heldResults++;
			end
		end
		doCredit = (owed > 0) && !holdCredits;
		if (doCredit)
			owed--;
		#1;
		resCredit = doCredit;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycleLimit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(91111));
		instrValid = 1'b0;
		instr = '0;
		loadValid = 1'b0;
		loadReg = '0;
		loadData = '0;
		resCredit = 1'b0;
		holdCredits = 1'b0;
		errors = 0;
		cycles = 0;
		sent = 0;
		instrReturned = 0;
		loadsSent = 0;
		loadReturned = 0;
		gotCount = 0;
		owed = 0;
		heldResults = 0;
		mCarry = 1'b0;
		for (int r = 0; r < 16; r++)
			mRegs[r] = 32'd0;
		buildTable();
		cycleLimit = 40 * rowInstr.size() + 200;

		while (reset !== 1'b0)
			tick();
		// Outputs stay quiet before any traffic
		repeat (8)
		begin
			tick();
			compareValue("resValid idle", 0, 64'(resValid));
			compareValue("instrCredit idle", 0, 64'(instrCredit));
			compareValue("loadCredit idle", 0, 64'(loadCredit));
		end

		applyRows(0, holdStart - 1);
		while (gotCount < holdStart)
			tick();

		holdCredits = 1'b1;
		applyRows(holdStart, rowInstr.size() - 1);
		repeat (20)
			tick();
		compareValue("results while credit withheld", `RESULT_CREDITS, 64'(heldResults));
		holdCredits = 1'b0;

		while (gotCount < rowInstr.size() || loadsSent != loadReturned)
			tick();
		repeat (4)
			tick();
		compareValue("instrCredit pulses", 64'(sent), 64'(instrReturned));
		compareValue("loadCredit pulses", 64'(loadsSent), 64'(loadReturned));
		compareValue("result count", 64'(rowInstr.size()), 64'(gotCount));

		$display("Run finished: %0d instructions, %0d loads, %0d errors", sent, loadsSent,
			errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- flist.f
+incdir+verilog
verilog/execPkg.sv
verilog/regWriteIf.sv
verilog/creditFifo.sv
verilog/intAlu.sv
verilog/executeStage.sv
verilog/writeArbiter.sv
verilog/regFile.sv
verilog/execCluster.sv
bench/clockGen.sv
bench/execCluster_properties.sv
bench/execCluster_tb.sv

//--- Makefile
# Verilator build for the execute cluster testbench

VERILATOR ?= verilator
TOP       ?= execCluster_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= SIMULATION PASSED

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST) verilog/exec_config.svh
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
